/* hw/decode_pkg.sv */
// decode stage package with the word width, opcode map and control field encodings.
`default_nettype none

package decode_pkg;

   localparam int word_w     = 16;     // data and address width.
   localparam int reg_addr_w = 3;      // eight registers.

   ////////////////////////////////////////
   // opcodes, inst[15:11]
   ////////////////////////////////////////
   typedef enum logic [4:0] {
      op_halt  = 5'b00000,
      op_nop   = 5'b00001,
      op_j     = 5'b00100,
      op_jr    = 5'b00101,
      op_jal   = 5'b00110,
      op_jalr  = 5'b00111,
      op_addi  = 5'b01000,
      op_subi  = 5'b01001,
      op_xori  = 5'b01010,
      op_andni = 5'b01011,
      op_beqz  = 5'b01100,
      op_bnez  = 5'b01101,
      op_bltz  = 5'b01110,
      op_bgez  = 5'b01111,
      op_st    = 5'b10000,
      op_ld    = 5'b10001,
      op_lbi   = 5'b11000,
      op_rfmt  = 5'b11011      // function in inst[1:0].
   } opcode_t;

   typedef enum logic [3:0] {
      alu_add    = 4'h0,
      alu_sub    = 4'h1,
      alu_xor    = 4'h2,
      alu_andn   = 4'h3,
      alu_pass_b = 4'h4        // lbi moves the immediate through.
   } alu_op_t;

   typedef enum logic [1:0] {
      ext_imm5  = 2'b00,       // inst[4:0].
      ext_imm8  = 2'b01,       // inst[7:0].
      ext_imm11 = 2'b10,       // inst[10:0].
      ext_none  = 2'b11
   } ext_op_t;

   typedef enum logic [2:0] {
      bj_none     = 3'b000,
      bj_beqz     = 3'b001,
      bj_bnez     = 3'b010,
      bj_bltz     = 3'b011,
      bj_bgez     = 3'b100,
      bj_jump_rel = 3'b101,
      bj_jump_reg = 3'b110
   } bj_op_t;

   // destination register field select.
   typedef enum logic [1:0] {
      dst_rd_r     = 2'b00,    // inst[4:2].
      dst_rd_i     = 2'b01,    // inst[7:5].
      dst_rs_field = 2'b10,    // inst[10:8].
      dst_link     = 2'b11     // r7.
   } dst_sel_t;

   localparam logic [reg_addr_w-1:0] link_reg = 3'b111;

endpackage

`default_nettype wire

/* hw/decode_control.sv */
// decode control that maps opcode and function bits onto the stage control fields.
`timescale 1ns/10ps
`default_nettype none

module decode_control (
   input  wire  [decode_pkg::word_w-1:0] inst,
   output decode_pkg::alu_op_t  alu_op,
   output decode_pkg::bj_op_t   bj_op,
   output decode_pkg::ext_op_t  ext_op,
   output logic                 ext_sign,
   output decode_pkg::dst_sel_t dst_sel,
   output logic                 reg_write,
   output logic                 mem_read,
   output logic                 mem_write,
   output logic                 mem_en,
   output logic                 mem_to_reg,
   output logic                 alu_src,
   output logic                 jal,
   output logic                 excp
);
   import decode_pkg::*;

   opcode_t opcode;

   assign opcode = opcode_t'(inst[15:11]);

   always_comb begin
      // halt and nop keep all of these.
      alu_op     = alu_add;
      bj_op      = bj_none;
      ext_op     = ext_none;
      ext_sign   = 1'b0;
      dst_sel    = dst_rd_r;
      reg_write  = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_en     = 1'b0;
      mem_to_reg = 1'b0;
      alu_src    = 1'b0;
      jal        = 1'b0;
      excp       = 1'b0;

      case (opcode)
         op_halt, op_nop: begin
         end
         op_rfmt: begin
            reg_write = 1'b1;
            case (inst[1:0])
               2'b00:   alu_op = alu_add;
               2'b01:   alu_op = alu_sub;
               2'b10:   alu_op = alu_xor;
               default: alu_op = alu_andn;
            endcase
         end
         op_addi, op_subi, op_xori, op_andni: begin
            ext_op    = ext_imm5;
            ext_sign  = (opcode == op_addi) || (opcode == op_subi); // logic ops zero-extend.
            dst_sel   = dst_rd_i;
            reg_write = 1'b1;
            alu_src   = 1'b1;
            case (opcode)
               op_subi: alu_op = alu_sub;
               op_xori: alu_op = alu_xor;
               op_andni: alu_op = alu_andn;
               default: alu_op = alu_add;
            endcase
         end
         op_st, op_ld: begin
            ext_op     = ext_imm5;
            ext_sign   = 1'b1;
            alu_src    = 1'b1;             // base plus offset.
            mem_en     = 1'b1;
            mem_write  = (opcode == op_st);
            mem_read   = (opcode == op_ld);
            mem_to_reg = (opcode == op_ld);
            reg_write  = (opcode == op_ld);
            dst_sel    = dst_rd_i;
         end
         op_beqz, op_bnez, op_bltz, op_bgez: begin
            ext_op   = ext_imm8;
            ext_sign = 1'b1;
            case (opcode)
               op_beqz: bj_op = bj_beqz;
               op_bnez: bj_op = bj_bnez;
               op_bltz: bj_op = bj_bltz;
               default: bj_op = bj_bgez;
            endcase
         end
         op_lbi: begin
            ext_op    = ext_imm8;
            ext_sign  = 1'b1;
            alu_op    = alu_pass_b;
            alu_src   = 1'b1;
            dst_sel   = dst_rs_field;
            reg_write = 1'b1;
         end
         op_j, op_jal: begin
            ext_op    = ext_imm11;
            ext_sign  = 1'b1;
            bj_op     = bj_jump_rel;
            jal       = (opcode == op_jal);
            reg_write = (opcode == op_jal);
            dst_sel   = dst_link;
         end
         op_jr, op_jalr: begin
            ext_op    = ext_imm8;
            ext_sign  = 1'b1;
            bj_op     = bj_jump_reg;
            jal       = (opcode == op_jalr);
            reg_write = (opcode == op_jalr);
            dst_sel   = dst_link;
         end
         default: begin
            excp      = 1'b1;              // opcode outside the supported subset.
            reg_write = 1'b0;
            mem_en    = 1'b0;
            bj_op     = bj_none;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// register file with eight words, two combinational reads and one clocked write.
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
   parameter bit bypass = 1'b1
) (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire  [decode_pkg::reg_addr_w-1:0] read1_sel,
   input  wire  [decode_pkg::reg_addr_w-1:0] read2_sel,
   input  wire  [decode_pkg::reg_addr_w-1:0] write_sel,
   input  wire  [decode_pkg::word_w-1:0]     write_data,
   input  wire                               write_en,
   output logic [decode_pkg::word_w-1:0]     read1_data,
   output logic [decode_pkg::word_w-1:0]     read2_data
);
   import decode_pkg::*;

   localparam int num_regs = 2 ** reg_addr_w;

   logic [word_w-1:0] regs [num_regs];
   logic [word_w-1:0] stored1;
   logic [word_w-1:0] stored2;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en) begin
         regs[write_sel] <= write_data;
      end
   end

   assign stored1 = regs[read1_sel];
   assign stored2 = regs[read2_sel];

   ////////////////////////////////////////
   // write to read forwarding
   ////////////////////////////////////////
   if (bypass) begin : g_bypass
      assign read1_data = (write_en && (write_sel == read1_sel)) ? write_data : stored1;
      assign read2_data = (write_en && (write_sel == read2_sel)) ? write_data : stored2;
   end else begin : g_direct
      assign read1_data = stored1;         // new value shows after the edge.
      assign read2_data = stored2;
   end

   assert property (@(posedge clk) disable iff (!rst_n) write_en |-> !$isunknown(write_sel));

endmodule

`default_nettype wire

/* hw/imm_extend.sv */
// immediate extension, selects the 5, 8 or 11 bit field and fills the upper bits.
`timescale 1ns/10ps
`default_nettype none

module imm_extend (
   input  wire  [decode_pkg::word_w-1:0] inst,
   input  wire  decode_pkg::ext_op_t     ext_op,
   input  wire                           ext_sign,
   output logic [decode_pkg::word_w-1:0] immediate
);
   import decode_pkg::*;

   logic fill;                             // bit copied into the upper part.

   always_comb begin
      case (ext_op)
         ext_imm5: begin
            fill      = ext_sign & inst[4];
            immediate = {{(word_w-5){fill}}, inst[4:0]};
         end
         ext_imm8: begin
            fill      = ext_sign & inst[7];
            immediate = {{(word_w-8){fill}}, inst[7:0]};
         end
         ext_imm11: begin
            fill      = ext_sign & inst[10];
            immediate = {{(word_w-11){fill}}, inst[10:0]};
         end
         default: begin
            fill      = 1'b0;
            immediate = '0;                // no immediate in this format.
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/branch_target.sv */
// branch and jump target, resolves the next pc and the link value.
`timescale 1ns/10ps
`default_nettype none

module branch_target (
   input  wire  [decode_pkg::word_w-1:0] rs_data,
   input  wire  [decode_pkg::word_w-1:0] pc,
   input  wire  [decode_pkg::word_w-1:0] immediate,
   input  wire  decode_pkg::bj_op_t      bj_op,
   output logic [decode_pkg::word_w-1:0] target,
   output logic [decode_pkg::word_w-1:0] link_data
);
   import decode_pkg::*;

   logic [word_w-1:0] pc_inc;
   logic              rs_zero;
   logic              taken;

   assign pc_inc    = pc + word_w'(2);
   assign link_data = pc_inc;              // return address for jal and jalr.
   assign rs_zero   = (rs_data == '0);

   always_comb begin
      case (bj_op)
         bj_beqz: taken = rs_zero;
         bj_bnez: taken = !rs_zero;
         bj_bltz: taken = rs_data[word_w-1];
         bj_bgez: taken = !rs_data[word_w-1];
         default: taken = 1'b0;
      endcase

      case (bj_op)
         bj_jump_rel: target = pc_inc + immediate;
         bj_jump_reg: target = rs_data + immediate;
         default:     target = taken ? (pc_inc + immediate) : pc_inc;
      endcase

      // code 3'b111 has no meaning and must never come out of control.
      assert (bj_op inside {bj_none, bj_beqz, bj_bnez, bj_bltz, bj_bgez,
                            bj_jump_rel, bj_jump_reg});
   end

endmodule

`default_nettype wire

/* hw/decode.sv */
// decode stage top, joins control, register file, extension and target logic.
`timescale 1ns/10ps
`default_nettype none

module decode #(
   parameter bit bypass = 1'b1
) (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire  [decode_pkg::word_w-1:0] inst,
   input  wire  [decode_pkg::word_w-1:0] pc,
   input  wire  [decode_pkg::word_w-1:0] wb_data,
   output logic [decode_pkg::word_w-1:0] data_one,     // rs.
   output logic [decode_pkg::word_w-1:0] data_two,     // rt.
   output logic [decode_pkg::word_w-1:0] immediate,
   output logic [decode_pkg::word_w-1:0] br_ju_addr,
   output decode_pkg::alu_op_t           alu_op,
   output decode_pkg::bj_op_t            bj_op,
   output decode_pkg::ext_op_t           ext_op,
   output logic                          reg_write,
   output logic                          mem_read,
   output logic                          mem_write,
   output logic                          mem_en,
   output logic                          mem_to_reg,
   output logic                          alu_src,
   output logic                          jal,
   output logic                          excp
);
   import decode_pkg::*;

   dst_sel_t              dst_sel;
   logic                  ext_sign;
   logic [reg_addr_w-1:0] write_sel;
   logic [word_w-1:0]     write_data;
   logic [word_w-1:0]     link_data;

   ////////////////////////////////////////
   // write port selection
   ////////////////////////////////////////
   always_comb begin
      case (dst_sel)
         dst_rd_r:     write_sel = inst[4:2];
         dst_rd_i:     write_sel = inst[7:5];
         dst_rs_field: write_sel = inst[10:8];
         default:      write_sel = link_reg;
      endcase
   end

   assign write_data = jal ? link_data : wb_data;  // link beats write-back.

   decode_control i_decode_control (
      .inst(inst), .alu_op(alu_op), .bj_op(bj_op), .ext_op(ext_op), .ext_sign(ext_sign),
      .dst_sel(dst_sel), .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
      .mem_en(mem_en), .mem_to_reg(mem_to_reg), .alu_src(alu_src), .jal(jal), .excp(excp)
   );

   reg_file #(.bypass(bypass)) i_reg_file (
      .clk(clk), .rst_n(rst_n), .read1_sel(inst[10:8]), .read2_sel(inst[7:5]),
      .write_sel(write_sel), .write_data(write_data), .write_en(reg_write),
      .read1_data(data_one), .read2_data(data_two)
   );

   imm_extend i_imm_extend (
      .inst(inst), .ext_op(ext_op), .ext_sign(ext_sign), .immediate(immediate)
   );

   branch_target i_branch_target (
      .rs_data(data_one), .pc(pc), .immediate(immediate), .bj_op(bj_op),
      .target(br_ju_addr), .link_data(link_data)
   );

endmodule

`default_nettype wire

/* dv/decode_vectors.svh */
// decode stage test table, one instruction per row applied once per cycle.
// columns are inst, pc, wb_data, random wb flag, alu_op, bj_op, ext_op,
// control bits {reg_write, mem_read, mem_write, mem_en, mem_to_reg, alu_src, jal, excp}, imm.

   // nop reads of every register pair after reset.
   add_row(16'h0800, 16'h0000, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h0940, 16'h0002, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h0b80, 16'h0004, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h0dc0, 16'h0006, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h0fe0, 16'h0008, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);

   // lbi into r1, r2, r3.
   add_row(16'hc185, 16'h0010, 16'h0000, 1'b1, alu_pass_b, bj_none, ext_imm8, 8'h84, 16'hff85);
   add_row(16'hc27f, 16'h0012, 16'h0000, 1'b1, alu_pass_b, bj_none, ext_imm8, 8'h84, 16'h007f);
   add_row(16'hc300, 16'h0014, 16'h0000, 1'b1, alu_pass_b, bj_none, ext_imm8, 8'h84, 16'h0000);

   // r-format, rd in inst[4:2]. xor row reads and writes r5.
   add_row(16'hd950, 16'h0016, 16'h0000, 1'b1, alu_add, bj_none, ext_none, 8'h80, 16'h0000);
   add_row(16'hdc35, 16'h0018, 16'h0000, 1'b1, alu_sub, bj_none, ext_none, 8'h80, 16'h0000);
   add_row(16'hddb6, 16'h001a, 16'h0000, 1'b1, alu_xor, bj_none, ext_none, 8'h80, 16'h0000);
   add_row(16'hda7b, 16'h001c, 16'h0000, 1'b1, alu_andn, bj_none, ext_none, 8'h80, 16'h0000);

   // i-format, rd in inst[7:5].
   add_row(16'h41d0, 16'h0020, 16'h0000, 1'b1, alu_add, bj_none, ext_imm5, 8'h84, 16'hfff0);
   add_row(16'h4aef, 16'h0022, 16'h0000, 1'b1, alu_sub, bj_none, ext_imm5, 8'h84, 16'h000f);
   add_row(16'h533f, 16'h0024, 16'h0000, 1'b1, alu_xor, bj_none, ext_imm5, 8'h84, 16'h001f);
   add_row(16'h5c55, 16'h0026, 16'h0000, 1'b1, alu_andn, bj_none, ext_imm5, 8'h84, 16'h0015);

   // store writes nothing, load writes rd.
   add_row(16'h815c, 16'h0028, 16'hdead, 1'b0, alu_add, bj_none, ext_imm5, 8'h34, 16'hfffc);
   add_row(16'h8b84, 16'h002a, 16'h0000, 1'b1, alu_add, bj_none, ext_imm5, 8'hdc, 16'h0004);
   add_row(16'h0000, 16'h002c, 16'hbeef, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h0ca0, 16'h002e, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h0ee0, 16'h0030, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);

   // undefined opcodes.
   add_row(16'h1123, 16'h0032, 16'h1234, 1'b0, alu_add, bj_none, ext_none, 8'h01, 16'h0000);
   add_row(16'hf8ff, 16'h0034, 16'h1234, 1'b0, alu_add, bj_none, ext_none, 8'h01, 16'h0000);
   add_row(16'h92a4, 16'h0036, 16'h1234, 1'b0, alu_add, bj_none, ext_none, 8'h01, 16'h0000);

   // zero, positive and negative values for the branch tests.
   add_row(16'hc100, 16'h0038, 16'h0000, 1'b0, alu_pass_b, bj_none, ext_imm8, 8'h84, 16'h0000);
   add_row(16'hc201, 16'h003a, 16'h0123, 1'b0, alu_pass_b, bj_none, ext_imm8, 8'h84, 16'h0001);
   add_row(16'hc3ff, 16'h003c, 16'h8001, 1'b0, alu_pass_b, bj_none, ext_imm8, 8'h84, 16'hffff);

   add_row(16'h6110, 16'h0100, 16'h0000, 1'b0, alu_add, bj_beqz, ext_imm8, 8'h00, 16'h0010);
   add_row(16'h62f0, 16'h0102, 16'h0000, 1'b0, alu_add, bj_beqz, ext_imm8, 8'h00, 16'hfff0);
   add_row(16'h6a08, 16'h0104, 16'h0000, 1'b0, alu_add, bj_bnez, ext_imm8, 8'h00, 16'h0008);
   add_row(16'h6980, 16'h0106, 16'h0000, 1'b0, alu_add, bj_bnez, ext_imm8, 8'h00, 16'hff80);
   add_row(16'h73fe, 16'h0108, 16'h0000, 1'b0, alu_add, bj_bltz, ext_imm8, 8'h00, 16'hfffe);
   add_row(16'h7220, 16'h010a, 16'h0000, 1'b0, alu_add, bj_bltz, ext_imm8, 8'h00, 16'h0020);
   add_row(16'h7940, 16'h010c, 16'h0000, 1'b0, alu_add, bj_bgez, ext_imm8, 8'h00, 16'h0040);
   add_row(16'h7b7f, 16'h010e, 16'h0000, 1'b0, alu_add, bj_bgez, ext_imm8, 8'h00, 16'h007f);

   // jumps. jal and jalr write pc+2 into r7, the nops read it back.
   add_row(16'h2400, 16'h1000, 16'h0000, 1'b0, alu_add, bj_jump_rel, ext_imm11, 8'h00, 16'hfc00);
   add_row(16'h2123, 16'h1002, 16'h0000, 1'b0, alu_add, bj_jump_rel, ext_imm11, 8'h00, 16'h0123);
   add_row(16'h2a84, 16'h1004, 16'h0000, 1'b0, alu_add, bj_jump_reg, ext_imm8, 8'h00, 16'hff84);
   add_row(16'h37ff, 16'h2000, 16'hface, 1'b0, alu_add, bj_jump_rel, ext_imm11, 8'h82, 16'hffff);
   add_row(16'h0f00, 16'h2002, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);
   add_row(16'h3b02, 16'h3000, 16'hface, 1'b0, alu_add, bj_jump_reg, ext_imm8, 8'h82, 16'h0002);
   add_row(16'h08e0, 16'h3002, 16'h0000, 1'b0, alu_add, bj_none, ext_none, 8'h00, 16'h0000);

/* dv/decode_tb.sv */
// decode stage testbench, table driven with a model of the register file.
`timescale 1ns/10ps
`default_nettype none

module decode_tb;
   import decode_pkg::*;

   logic              clk;
   logic              rst_n;
   logic [word_w-1:0] inst;
   logic [word_w-1:0] pc;
   logic [word_w-1:0] wb_data;
   logic [word_w-1:0] data_one;
   logic [word_w-1:0] data_two;
   logic [word_w-1:0] immediate;
   logic [word_w-1:0] br_ju_addr;
   alu_op_t           alu_op;
   bj_op_t            bj_op;
   ext_op_t           ext_op;
   logic              reg_write;
   logic              mem_read;
   logic              mem_write;
   logic              mem_en;
   logic              mem_to_reg;
   logic              alu_src;
   logic              jal;
   logic              excp;

   // table columns.
   logic [word_w-1:0] tab_inst [$];
   logic [word_w-1:0] tab_pc [$];
   logic [word_w-1:0] tab_wb [$];
   logic              tab_rnd [$];
   alu_op_t           tab_alu [$];
   bj_op_t            tab_bj [$];
   ext_op_t           tab_ext [$];
   logic [7:0]        tab_ctrl [$];
   logic [word_w-1:0] tab_imm [$];

   logic [word_w-1:0] model_regs [8];
   logic [31:0]       seed;
   int                cycles;
   int                cycle_limit;
   int                cur_row;
   int                row_errors;
   int                rows_passed;
   int                rows_failed;

   decode #(.bypass(1'b1)) i_decode (
      .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .wb_data(wb_data),
      .data_one(data_one), .data_two(data_two), .immediate(immediate),
      .br_ju_addr(br_ju_addr), .alu_op(alu_op), .bj_op(bj_op), .ext_op(ext_op),
      .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write), .mem_en(mem_en),
      .mem_to_reg(mem_to_reg), .alu_src(alu_src), .jal(jal), .excp(excp)
   );

   task automatic add_row(input logic [word_w-1:0] i_word, input logic [word_w-1:0] pc_val,
                          input logic [word_w-1:0] wb_val, input logic rnd,
                          input alu_op_t alu, input bj_op_t bj, input ext_op_t ext,
                          input logic [7:0] ctrl, input logic [word_w-1:0] imm);
      tab_inst.push_back(i_word);
      tab_pc.push_back(pc_val);
      tab_wb.push_back(wb_val);
      tab_rnd.push_back(rnd);
      tab_alu.push_back(alu);
      tab_bj.push_back(bj);
      tab_ext.push_back(ext);
      tab_ctrl.push_back(ctrl);
      tab_imm.push_back(imm);
   endtask

   task automatic load_table();
      `include "decode_vectors.svh"
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: row %0d %s is %h, expected %h", $time, cur_row, what, got, exp);
         row_errors++;
      end
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // destination register by instruction format.
   function automatic logic [2:0] dest_of(input logic [word_w-1:0] word);
      if (word[15:11] == op_rfmt) return word[4:2];
      if (word[15:11] == op_lbi) return word[10:8];
      if (word[15:11] == op_jal || word[15:11] == op_jalr) return link_reg;
      return word[7:5];
   endfunction

   function automatic logic [word_w-1:0] expected_target(input bj_op_t bj,
         input logic [word_w-1:0] rs, input logic [word_w-1:0] pc_now,
         input logic [word_w-1:0] imm);
      logic [word_w-1:0] fall;
      fall = pc_now + 16'd2;
      if (bj == bj_jump_reg) return rs + imm;
      if (bj == bj_jump_rel) return fall + imm;
      if ((bj == bj_beqz && rs == 16'h0000) || (bj == bj_bnez && rs != 16'h0000) ||
          (bj == bj_bltz && rs[15]) || (bj == bj_bgez && !rs[15])) return fall + imm;
      return fall;
   endfunction

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // run limit
   ////////////////////////////////////////
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("simulation timed out after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // stimulus and checks
   ////////////////////////////////////////
   initial begin
      logic [word_w-1:0] wb_now;
      logic [word_w-1:0] exp_one;
      logic [word_w-1:0] exp_two;
      logic [word_w-1:0] exp_wdata;
      logic [2:0]        wsel;
      rst_n       = 1'b0;
      inst        = '0;                    // halt, no write during reset.
      pc          = '0;
      wb_data     = '0;
      cycles      = 0;
      rows_passed = 0;
      rows_failed = 0;
      seed        = 32'h575a_ec9b;
      load_table();
      cycle_limit = 2 * tab_inst.size() + 20;
      for (int k = 0; k < 8; k++) begin
         model_regs[k] = '0;
      end
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int r = 0; r < tab_inst.size(); r++) begin
         cur_row    = r;
         row_errors = 0;
         if (tab_rnd[r]) begin
            seed   = lcg_next(seed);
            wb_now = seed[31:16];              // upper bits are the better mixed.
         end else begin
            wb_now = tab_wb[r];
         end
         inst    = tab_inst[r];
         pc      = tab_pc[r];
         wb_data = wb_now;

         wsel      = dest_of(tab_inst[r]);
         exp_wdata = tab_ctrl[r][1] ? tab_pc[r] + 16'd2 : wb_now;
         exp_one   = model_regs[tab_inst[r][10:8]];
         exp_two   = model_regs[tab_inst[r][7:5]];
         if (tab_ctrl[r][7] && wsel == tab_inst[r][10:8]) exp_one = exp_wdata; // bypass.
         if (tab_ctrl[r][7] && wsel == tab_inst[r][7:5]) exp_two = exp_wdata;

         #2;                                   // outputs settled before next edge.
         check_value("control bits", {reg_write, mem_read, mem_write, mem_en,
                     mem_to_reg, alu_src, jal, excp}, tab_ctrl[r]);
         check_value("alu_op", alu_op, tab_alu[r]);
         check_value("bj_op", bj_op, tab_bj[r]);
         check_value("ext_op", ext_op, tab_ext[r]);
         check_value("immediate", immediate, tab_imm[r]);
         check_value("data_one", data_one, exp_one);
         check_value("data_two", data_two, exp_two);
         check_value("br_ju_addr", br_ju_addr,
                     expected_target(tab_bj[r], exp_one, tab_pc[r], tab_imm[r]));

         if (tab_ctrl[r][7]) model_regs[wsel] = exp_wdata;
         if (row_errors == 0) rows_passed++;
         else rows_failed++;
         $display("row %0d inst %h pc %h: %s", r, tab_inst[r], tab_pc[r],
                  (row_errors == 0) ? "ok" : "mismatch");
         @(posedge clk);
         #1;
      end

      $display("rows passed %0d, rows failed %0d", rows_passed, rows_failed);
      if (rows_failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+dv
hw/decode_pkg.sv
hw/decode_control.sv
hw/reg_file.sv
hw/imm_extend.sv
hw/branch_target.sv
hw/decode.sv
dv/decode_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out="$(./obj_dir/decode_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
